// File: common/router_settings.svh
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// Port counts on each side of the router
`define NUM_USERS 3
`define NUM_LANES 2

// Payload word width on user ports and lanes
`define DATA_W 64

// Device id also indexes the routing table (16 entries)
`define DEVICE_ID_W 4

// Local user index, joined to the device id in src_addr
`define USER_ID_W 2

// Opaque user metadata carried in the header
`define META_W 8

// Lane index stored in a table entry
`define LANE_ID_W 1

// Flit and drop counters
`define CNT_W 16

`endif

// File: common/router_pkg.sv
`default_nettype none

`include "router_settings.svh"

package router_pkg;

  // One word as presented by a user port
  typedef struct packed {
    logic                    valid;
    logic                    last;
    logic [`DEVICE_ID_W-1:0] address;
    logic [`META_W-1:0]      metadata;
    logic [`DATA_W-1:0]      data;
  } user_word_t;

  // Source address is device id followed by user id
  typedef struct packed {
    logic [`DEVICE_ID_W-1:0]            dest_addr;
    logic [`DEVICE_ID_W+`USER_ID_W-1:0] src_addr;
    logic [`META_W-1:0]                 metadata;
  } packet_header_t;

  // Framed word on the shared network path
  typedef struct packed {
    packet_header_t     header;
    logic               first;
    logic               valid;
    logic               last;
    logic [`DATA_W-1:0] data;
  } packet_word_t;

  // Zero padding above the header inside a flit
  localparam int HDR_PAD_W = `DATA_W - $bits(packet_header_t);

  typedef struct packed {
    logic [HDR_PAD_W-1:0] pad;
    packet_header_t       header;
  } header_view_t;

  // A lane flit is either a header or raw payload
  typedef union packed {
    header_view_t       hdr;
    logic [`DATA_W-1:0] data;
  } lane_flit_u;

  typedef struct packed {
    logic       valid;
    logic       is_header;
    logic       last;
    lane_flit_u flit;
  } lane_out_t;

  typedef struct packed {
    logic                  valid;
    logic [`LANE_ID_W-1:0] lane;
  } route_entry_t;

  typedef struct packed {
    logic                    we;
    logic [`DEVICE_ID_W-1:0] addr;
    route_entry_t            entry;
  } table_write_t;

endpackage

`default_nettype wire

// File: src/packet_framer.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module packet_framer (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire  [`USER_ID_W-1:0]         user_id,
  input  wire  [`DEVICE_ID_W-1:0]       device_id,
  input  wire  router_pkg::user_word_t  user_in,
  output logic                          user_ready,
  output router_pkg::packet_word_t      word_out,
  input  wire                           word_ready
);

  // High while a packet from this user is open
  logic locked;
  logic accept;
  router_pkg::packet_header_t header;

  assign accept = user_in.valid && word_ready;

  // Lock opens on a non-last word and closes on the last one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      locked <= 1'b0;
    end else if (accept) begin
      locked <= !user_in.last;
    end
  end

  always_comb begin
    header.dest_addr = user_in.address;
    header.src_addr  = {device_id, user_id};
    header.metadata  = user_in.metadata;
  end

  // Header rides along with every word, first marks the packet start
  always_comb begin
    word_out.header = header;
    word_out.first  = user_in.valid && !locked;
    word_out.valid  = user_in.valid;
    word_out.last   = user_in.last;
    word_out.data   = user_in.data;
  end

  assign user_ready = word_ready;

endmodule

`default_nettype wire

// File: src/user_tx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module user_tx_arbiter (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire router_pkg::packet_word_t req_words [`NUM_USERS],
  output logic                          req_ready [`NUM_USERS],
  output router_pkg::packet_word_t      grant_word,
  input  wire                           grant_ready
);

  localparam int IDX_W = $clog2(`NUM_USERS);

  // Search start for the next free choice
  logic [IDX_W-1:0] rr_ptr;
  // Grant kept across the words of one packet
  logic             held;
  logic [IDX_W-1:0] held_idx;

  logic [IDX_W-1:0] sel_idx;
  logic             sel_found;
  logic             xfer;

  always_comb begin
    int cand;
    sel_idx   = held_idx;
    sel_found = held;
    cand      = 0;
    if (!held) begin
      for (int k = 0; k < `NUM_USERS; k++) begin
        cand = (int'(rr_ptr) + k) % `NUM_USERS;
        if (!sel_found && req_words[cand].valid) begin
          sel_idx   = IDX_W'(cand);
          sel_found = 1'b1;
        end
      end
    end
  end

  assign grant_word = sel_found ? req_words[sel_idx] : '0;
  assign xfer       = grant_word.valid && grant_ready;

  // Only the selected user sees ready
  always_comb begin
    for (int i = 0; i < `NUM_USERS; i++) begin
      req_ready[i] = sel_found && (int'(sel_idx) == i) && grant_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rr_ptr   <= '0;
      held     <= 1'b0;
      held_idx <= '0;
    end else if (xfer) begin
      if (grant_word.last) begin
        // Packet done, next search starts after this user
        held <= 1'b0;
        if (int'(sel_idx) == `NUM_USERS - 1) begin
          rr_ptr <= '0;
        end else begin
          rr_ptr <= sel_idx + 1'b1;
        end
      end else begin
        held     <= 1'b1;
        held_idx <= sel_idx;
      end
    end
  end

endmodule

`default_nettype wire

// File: network/route_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module route_table (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire router_pkg::table_write_t table_wr,
  input  wire router_pkg::packet_word_t word_in,
  output logic                          word_ready,
  output logic [`NUM_LANES-1:0]         lane_valid,
  input  wire  [`NUM_LANES-1:0]         lane_ready,
  output logic [`CNT_W-1:0]             drop_count
);

  localparam int TABLE_DEPTH = 1 << `DEVICE_ID_W;

  router_pkg::route_entry_t table_q [TABLE_DEPTH];
  // Route of the packet in flight
  router_pkg::route_entry_t route_q;
  router_pkg::route_entry_t route;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < TABLE_DEPTH; k++) begin
        table_q[k] <= '0;
      end
    end else if (table_wr.we) begin
      table_q[table_wr.addr] <= table_wr.entry;
    end
  end

  // First word looks up, the rest reuse the latched route
  assign route = word_in.first ? table_q[word_in.header.dest_addr] : route_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      route_q <= '0;
    end else if (word_in.valid && word_ready && word_in.first) begin
      route_q <= route;
    end
  end

  always_comb begin
    for (int j = 0; j < `NUM_LANES; j++) begin
      lane_valid[j] = word_in.valid && route.valid && (route.lane == `LANE_ID_W'(j));
    end
  end

  // Unrouted words are sunk one per cycle
  assign word_ready = route.valid ? lane_ready[route.lane] : 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (word_in.valid && !route.valid && word_in.last) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: network/lane_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module lane_tx (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire router_pkg::packet_word_t word_in,
  input  wire                           in_valid,
  output logic                          in_ready,
  input  wire                           lane_full,
  output router_pkg::lane_out_t         lane_out,
  output logic [`CNT_W-1:0]             sent_count
);

  router_pkg::lane_out_t  out_q;
  // Data flit waiting behind its header
  logic                   hdr_pending;
  router_pkg::lane_flit_u pend_q;
  logic                   pend_last;

  router_pkg::lane_flit_u hdr_flit;
  router_pkg::lane_flit_u data_flit;
  logic                   accept;
  logic                   flit_sent;

  // Same word seen through both views of the flit
  always_comb begin
    hdr_flit.hdr  = '{pad: '0, header: word_in.header};
    data_flit.data = word_in.data;
  end

  // No new word while full or while a header is still ahead of its data
  assign in_ready  = !lane_full && !hdr_pending;
  assign accept    = in_valid && in_ready;
  assign flit_sent = out_q.valid && !lane_full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_q.valid <= 1'b0;
      hdr_pending <= 1'b0;
    end else if (!lane_full) begin
      if (accept && word_in.first) begin
        out_q.valid     <= 1'b1;
        out_q.is_header <= 1'b1;
        out_q.last      <= 1'b0;
        out_q.flit      <= hdr_flit;
        hdr_pending     <= 1'b1;
      end else if (accept) begin
        out_q.valid     <= 1'b1;
        out_q.is_header <= 1'b0;
        out_q.last      <= word_in.last;
        out_q.flit      <= data_flit;
      end else if (hdr_pending) begin
        // Header has gone out, release the held data
        out_q.valid     <= 1'b1;
        out_q.is_header <= 1'b0;
        out_q.last      <= pend_last;
        out_q.flit      <= pend_q;
        hdr_pending     <= 1'b0;
      end else begin
        out_q.valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && word_in.first) begin
      pend_q    <= data_flit;
      pend_last <= word_in.last;
    end
  end

  // Count every flit the lane takes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sent_count <= '0;
    end else if (flit_sent) begin
      sent_count <= sent_count + 1'b1;
    end
  end

  assign lane_out = out_q;

endmodule

`default_nettype wire

// File: src/node_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module node_router (
  input  wire                           clk,
  input  wire                           rst_n,
  // Static configuration
  input  wire  [`DEVICE_ID_W-1:0]       device_id,
  input  wire router_pkg::table_write_t table_wr,
  // User ports
  input  wire router_pkg::user_word_t   users_tx [`NUM_USERS],
  output wire                           users_tx_ready [`NUM_USERS],
  // Lanes
  output wire router_pkg::lane_out_t    lane_out [`NUM_LANES],
  input  wire                           lane_full [`NUM_LANES],
  output wire  [`CNT_W-1:0]             lane_sent_count [`NUM_LANES],
  output wire  [`CNT_W-1:0]             drop_count
);

  wire router_pkg::packet_word_t framed_words [`NUM_USERS];
  wire                           framed_ready [`NUM_USERS];

  wire router_pkg::packet_word_t grant_word;
  wire                           grant_ready;

  wire [`NUM_LANES-1:0]          lane_valid;
  wire [`NUM_LANES-1:0]          lane_ready;

  // One framer per user, all feeding the arbiter
  for (genvar i = 0; i < `NUM_USERS; i++) begin : g_user
    packet_framer i_framer (
      .clk        (clk),
      .rst_n      (rst_n),
      .user_id    (`USER_ID_W'(i)),
      .device_id  (device_id),
      .user_in    (users_tx[i]),
      .user_ready (users_tx_ready[i]),
      .word_out   (framed_words[i]),
      .word_ready (framed_ready[i])
    );
  end

  user_tx_arbiter i_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_words   (framed_words),
    .req_ready   (framed_ready),
    .grant_word  (grant_word),
    .grant_ready (grant_ready)
  );

  route_table i_route_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .table_wr   (table_wr),
    .word_in    (grant_word),
    .word_ready (grant_ready),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .drop_count (drop_count)
  );

  // Every lane sees the granted word, only the routed one gets valid
  for (genvar j = 0; j < `NUM_LANES; j++) begin : g_lane
    lane_tx i_lane_tx (
      .clk        (clk),
      .rst_n      (rst_n),
      .word_in    (grant_word),
      .in_valid   (lane_valid[j]),
      .in_ready   (lane_ready[j]),
      .lane_full  (lane_full[j]),
      .lane_out   (lane_out[j]),
      .sent_count (lane_sent_count[j])
    );
  end

endmodule

`default_nettype wire

// File: bench/node_router_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module node_router_sva (
  input wire                        clk,
  input wire                        rst_n,
  input wire                        users_tx_ready [`NUM_USERS],
  input wire router_pkg::lane_out_t lane_out [`NUM_LANES],
  input wire                        lane_full [`NUM_LANES]
);

  logic [`NUM_USERS-1:0] ready_vec;

  always_comb begin
    for (int i = 0; i < `NUM_USERS; i++) begin
      ready_vec[i] = users_tx_ready[i];
    end
  end

  // Only the granted user may see ready
  a_one_ready: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ready_vec))
    else $error("More than one user port is ready");

  for (genvar j = 0; j < `NUM_LANES; j++) begin : g_lane
    // Stalled lane keeps its flit
    a_hold_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      lane_full[j] |=> $stable(lane_out[j]))
      else $error("Lane %0d changed its output while full", j);

    a_header_then_data: assert property (@(posedge clk) disable iff (!rst_n)
      (lane_out[j].valid && lane_out[j].is_header && !lane_full[j])
        |=> (lane_out[j].valid && !lane_out[j].is_header))
      else $error("Lane %0d header flit not followed by a data flit", j);
  end

endmodule

bind node_router node_router_sva i_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .users_tx_ready (users_tx_ready),
  .lane_out       (lane_out),
  .lane_full      (lane_full)
);

`default_nettype wire

// File: bench/node_router_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module node_router_tb;

  logic                     clk;
  logic                     rst_n;
  logic [`DEVICE_ID_W-1:0]  device_id;
  router_pkg::table_write_t table_wr;
  router_pkg::user_word_t   users_tx [`NUM_USERS];
  logic                     users_tx_ready [`NUM_USERS];
  router_pkg::lane_out_t    lane_out [`NUM_LANES];
  logic                     lane_full [`NUM_LANES];
  logic [`CNT_W-1:0]        lane_sent_count [`NUM_LANES];
  logic [`CNT_W-1:0]        drop_count;

  // Reference model of the table and the expected lane traffic
  router_pkg::route_entry_t route_model [1 << `DEVICE_ID_W];
  router_pkg::route_entry_t cur_route [`NUM_USERS];
  router_pkg::lane_out_t    exp_q [`NUM_LANES][$];
  int                       exp_total [`NUM_LANES];
  int                       exp_drops;
  int                       open_user;
  // Packets started by other users while this one waited
  int                       passed_over [`NUM_USERS];
  logic                     backpressure;
  int                       seed;
  int                       errors;
  int                       checks;

  node_router i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Random lane stalls during the back-pressure test
  initial begin
    for (int j = 0; j < `NUM_LANES; j++) lane_full[j] = 1'b0;
    forever begin
      @(negedge clk);
      for (int j = 0; j < `NUM_LANES; j++) begin
        lane_full[j] = backpressure && (($random(seed) & 3) == 0);
      end
    end
  end

  task automatic check_flit(input string name, input router_pkg::lane_out_t got,
                            input router_pkg::lane_out_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [`CNT_W-1:0] got,
                             input logic [`CNT_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // Each lane transfer must match the head of that lane's queue
  always @(posedge clk) begin
    if (rst_n) begin
      for (int j = 0; j < `NUM_LANES; j++) begin
        if (lane_out[j].valid && !lane_full[j]) begin
          if (exp_q[j].size() == 0) begin
            errors++;
            $display("Lane %0d sent a flit at %0t that no packet explains", j, $time);
          end else begin
            check_flit($sformatf("lane_out[%0d]", j), lane_out[j], exp_q[j].pop_front());
          end
        end
      end
    end
  end

  function automatic logic [`DATA_W-1:0] rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Turn one accepted user word into the flits its lane should send
  task automatic record_word(input int u, input router_pkg::user_word_t word, input logic first);
    router_pkg::lane_out_t flit;
    int                    lane;
    if ((first && open_user != -1) || (!first && open_user != u)) begin
      errors++;
      $display("User %0d word at %0t was accepted inside another user's packet", u, $time);
    end
    open_user = word.last ? -1 : u;
    if (first) begin
      // Round robin lets fewer than NUM_USERS packets start ahead of a waiting user
      for (int v = 0; v < `NUM_USERS; v++) begin
        if (v != u && users_tx[v].valid) begin
          passed_over[v]++;
          if (passed_over[v] >= `NUM_USERS) begin
            errors++;
            $display("User %0d was passed over %0d times at %0t", v, passed_over[v], $time);
          end
        end
      end
      passed_over[u] = 0;
      cur_route[u] = route_model[word.address];
    end
    lane = int'(cur_route[u].lane);
    if (!cur_route[u].valid) begin
      if (word.last) exp_drops++;
    end else begin
      if (first) begin
        flit = '0;
        flit.valid = 1'b1;
        flit.is_header = 1'b1;
        flit.flit.hdr.header.dest_addr = word.address;
        flit.flit.hdr.header.src_addr  = {device_id, `USER_ID_W'(u)};
        flit.flit.hdr.header.metadata  = word.metadata;
        exp_q[lane].push_back(flit);
        exp_total[lane]++;
      end
      flit = '0;
      flit.valid = 1'b1;
      flit.last = word.last;
      flit.flit.data = word.data;
      exp_q[lane].push_back(flit);
      exp_total[lane]++;
    end
  endtask

  task automatic send_packet(input int u, input logic [`DEVICE_ID_W-1:0] dest,
                             input logic [`META_W-1:0] meta, input int len,
                             input logic [`DATA_W-1:0] base);
    int cycles;
    for (int w = 0; w < len; w++) begin
      @(negedge clk);
      users_tx[u].valid    = 1'b1;
      users_tx[u].last     = (w == len - 1);
      users_tx[u].address  = dest;
      users_tx[u].metadata = meta;
      users_tx[u].data     = base + `DATA_W'(w);
      cycles = 0;
      do begin
        @(posedge clk);
        cycles++;
      end while (!users_tx_ready[u] && cycles < 300);
      if (!users_tx_ready[u]) begin
        errors++;
        $display("User %0d word %0d was never accepted", u, w);
        @(negedge clk);
        users_tx[u].valid = 1'b0;
        return;
      end
      record_word(u, users_tx[u], w == 0);
    end
    @(negedge clk);
    users_tx[u].valid = 1'b0;
  endtask

  task automatic program_route(input logic [`DEVICE_ID_W-1:0] dev, input logic valid,
                               input logic [`LANE_ID_W-1:0] lane);
    @(negedge clk);
    table_wr.we          = 1'b1;
    table_wr.addr        = dev;
    table_wr.entry.valid = valid;
    table_wr.entry.lane  = lane;
    route_model[dev]     = table_wr.entry;
    @(negedge clk);
    table_wr.we = 1'b0;
  endtask

  function automatic logic lanes_busy();
    for (int j = 0; j < `NUM_LANES; j++) begin
      if (exp_q[j].size() != 0 || lane_out[j].valid) return 1'b1;
    end
    return 1'b0;
  endfunction

  // Wait until every expected flit has left, then compare the counters
  task automatic drain_and_count();
    int cycles;
    cycles = 0;
    while (lanes_busy() && cycles < 500) begin
      @(negedge clk);
      cycles++;
    end
    if (lanes_busy()) begin
      errors++;
      $display("Lanes did not drain, %0d and %0d flits still expected",
               exp_q[0].size(), exp_q[1].size());
    end
    for (int j = 0; j < `NUM_LANES; j++) begin
      check_count($sformatf("lane_sent_count[%0d]", j), lane_sent_count[j],
                  `CNT_W'(exp_total[j]));
    end
    check_count("drop_count", drop_count, `CNT_W'(exp_drops));
  endtask

  task automatic test_single_words();
    program_route(4'd3, 1'b1, 1'b0);
    program_route(4'd9, 1'b1, 1'b1);
    for (int u = 0; u < `NUM_USERS; u++) begin
      send_packet(u, (u % 2 == 0) ? 4'd3 : 4'd9, 8'h10 + 8'(u), 1, rand_word());
    end
    drain_and_count();
  endtask

  task automatic test_multi_word();
    send_packet(1, 4'd9, 8'h5a, 5, rand_word());
    drain_and_count();
  endtask

  task automatic test_concurrent();
    fork
      begin
        send_packet(0, 4'd3, 8'ha0, 3, rand_word());
        send_packet(0, 4'd3, 8'ha1, 2, rand_word());
      end
      send_packet(2, 4'd3, 8'hc0, 4, rand_word());
      send_packet(1, 4'd9, 8'hb0, 3, rand_word());
    join
    drain_and_count();
  endtask

  task automatic test_drop_then_route();
    logic [`DATA_W-1:0] base;
    base = rand_word();
    send_packet(0, 4'd12, 8'h77, 2, base);
    drain_and_count();
    program_route(4'd12, 1'b1, 1'b1);
    send_packet(0, 4'd12, 8'h77, 2, base);
    drain_and_count();
  endtask

  task automatic test_backpressure();
    backpressure = 1'b1;
    fork
      for (int k = 0; k < 4; k++) send_packet(0, 4'd3, 8'(k), k + 1, rand_word());
      for (int k = 0; k < 4; k++) send_packet(1, 4'd9, 8'(k), 3 - k % 3, rand_word());
      for (int k = 0; k < 3; k++) send_packet(2, 4'd9, 8'(k), 2, rand_word());
    join
    drain_and_count();
    backpressure = 1'b0;
  endtask

  initial begin
    seed = 32'hf932;
    errors = 0;
    checks = 0;
    exp_drops = 0;
    open_user = -1;
    backpressure = 1'b0;
    rst_n = 1'b0;
    device_id = 4'h5;
    table_wr = '0;
    for (int u = 0; u < `NUM_USERS; u++) begin
      users_tx[u] = '0;
      passed_over[u] = 0;
      cur_route[u] = '0;
    end
    for (int j = 0; j < `NUM_LANES; j++) exp_total[j] = 0;
    for (int d = 0; d < (1 << `DEVICE_ID_W); d++) route_model[d] = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_single_words();
    test_multi_word();
    test_concurrent();
    test_drop_then_route();
    test_backpressure();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/router_pkg.sv
src/packet_framer.sv
src/user_tx_arbiter.sv
network/route_table.sv
network/lane_tx.sv
src/node_router.sv
bench/node_router_sva.sv
bench/node_router_tb.sv

// File: Makefile
sim:
	verilator --binary --assert -Wno-fatal -f list.f --top-module node_router_tb \
		-Mdir obj_dir -o node_router_tb
	./obj_dir/node_router_tb > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
